//--- verilog/sbox_pkg.sv
package sbox_pkg;

  localparam int LANE_W = 6;
  localparam int MAX_LANES = 16;

  typedef logic [1:0] gf4_t; // composite digit, x^2 = x + 1
  typedef logic [LANE_W-1:0] gf64_t; // three gf4 digits, digit 0 in bits 1:0

  typedef struct packed {
    gf64_t [MAX_LANES-1:0] lane; // lane 0 in the low bits
  } sbox_block_t;

  function automatic gf4_t gf4_add(gf4_t a, gf4_t b);
    gf4_t c;
    c = a ^ b;
    return c;
  endfunction

  // frobenius map, linear over GF(2)
  function automatic gf4_t gf4_sq(gf4_t a);
    gf4_t b;
    b[0] = a[0] ^ a[1];
    b[1] = a[1];
    return b;
  endfunction

  function automatic gf4_t gf4_mul(gf4_t a, gf4_t b);
    logic hi;
    gf4_t c;
    hi = a[1] & b[1]; // x^2 term folds back into both bits
    c[0] = (a[0] & b[0]) ^ hi;
    c[1] = (a[0] & b[1]) ^ (a[1] & b[0]) ^ hi;
    return c;
  endfunction

  // a^3 is 1 for any nonzero a in GF(4), so this is a^3 * b
  function automatic gf4_t gf4_qube_scale(gf4_t a, gf4_t b);
    logic nz;
    gf4_t c;
    nz = a[0] | a[1];
    c[0] = nz & b[0];
    c[1] = nz & b[1];
    return c;
  endfunction

endpackage

//--- verilog/gf64_power26.sv
`timescale 1ns/1ps

module gf64_power26 (
  input  sbox_pkg::gf64_t a,
  output sbox_pkg::gf64_t b
);

  sbox_pkg::gf4_t y0;
  sbox_pkg::gf4_t y1;
  sbox_pkg::gf4_t y2;
  sbox_pkg::gf4_t p12; // products of squared digits
  sbox_pkg::gf4_t p02;
  sbox_pkg::gf4_t p01;
  sbox_pkg::gf4_t term [0:14];
  sbox_pkg::gf4_t d0;
  sbox_pkg::gf4_t d1;
  sbox_pkg::gf4_t d2;

  assign y0 = a[1:0];
  assign y1 = a[3:2];
  assign y2 = a[5:4];

  // digit squares
  assign term[0] = sbox_pkg::gf4_sq(y0);
  assign term[1] = sbox_pkg::gf4_sq(y1);
  assign term[2] = sbox_pkg::gf4_sq(y2);

  // cube scalings, each square survives only where the other digit is nonzero
  assign term[3] = sbox_pkg::gf4_qube_scale(y1, term[0]);
  assign term[4] = sbox_pkg::gf4_qube_scale(y2, term[0]);
  assign term[5] = sbox_pkg::gf4_qube_scale(y0, term[1]);
  assign term[6] = sbox_pkg::gf4_qube_scale(y2, term[1]);
  assign term[7] = sbox_pkg::gf4_qube_scale(y0, term[2]);
  assign term[8] = sbox_pkg::gf4_qube_scale(y1, term[2]);

  // plain cross products
  assign term[9]  = sbox_pkg::gf4_mul(y0, y1);
  assign term[10] = sbox_pkg::gf4_mul(y0, y2);
  assign term[11] = sbox_pkg::gf4_mul(y1, y2);

  // three-digit products, one digit times the squares of the other two
  assign p12 = sbox_pkg::gf4_mul(term[1], term[2]);
  assign p02 = sbox_pkg::gf4_mul(term[0], term[2]);
  assign p01 = sbox_pkg::gf4_mul(term[0], term[1]);
  assign term[12] = sbox_pkg::gf4_mul(y0, p12);
  assign term[13] = sbox_pkg::gf4_mul(y1, p02);
  assign term[14] = sbox_pkg::gf4_mul(y2, p01);

  always_comb begin
    d0 = sbox_pkg::gf4_add(term[1], term[2]);
    d0 = sbox_pkg::gf4_add(d0, term[4]);
    d0 = sbox_pkg::gf4_add(d0, term[5]);
    d0 = sbox_pkg::gf4_add(d0, term[6]);
    d0 = sbox_pkg::gf4_add(d0, term[9]);
    d0 = sbox_pkg::gf4_add(d0, term[11]);
    d0 = sbox_pkg::gf4_add(d0, term[12]);
    d0 = sbox_pkg::gf4_add(d0, term[13]);
  end

  always_comb begin
    d1 = sbox_pkg::gf4_add(term[0], term[2]);
    d1 = sbox_pkg::gf4_add(d1, term[5]);
    d1 = sbox_pkg::gf4_add(d1, term[7]);
    d1 = sbox_pkg::gf4_add(d1, term[8]);
    d1 = sbox_pkg::gf4_add(d1, term[10]);
    d1 = sbox_pkg::gf4_add(d1, term[11]);
    d1 = sbox_pkg::gf4_add(d1, term[13]);
    d1 = sbox_pkg::gf4_add(d1, term[14]);
  end

  always_comb begin
    d2 = sbox_pkg::gf4_add(term[0], term[1]);
    d2 = sbox_pkg::gf4_add(d2, term[3]);
    d2 = sbox_pkg::gf4_add(d2, term[4]);
    d2 = sbox_pkg::gf4_add(d2, term[8]);
    d2 = sbox_pkg::gf4_add(d2, term[9]);
    d2 = sbox_pkg::gf4_add(d2, term[10]);
    d2 = sbox_pkg::gf4_add(d2, term[12]);
    d2 = sbox_pkg::gf4_add(d2, term[14]);
  end

  assign b = {d2, d1, d0};

endmodule

//--- verilog/sbox6.sv
`timescale 1ns/1ps

module sbox6 (
  input  sbox_pkg::gf64_t x,
  output sbox_pkg::gf64_t y
);

  sbox_pkg::gf64_t z; // x in composite basis
  sbox_pkg::gf64_t w; // z^26
  sbox_pkg::gf64_t p; // w back in standard basis
  logic mask;

  // forward basis change, standard to GF((2^2)^3)
  assign z[0] = x[0] ^ x[4] ^ x[5];
  assign z[1] = x[4];
  assign z[2] = x[0] ^ x[3];
  assign z[3] = x[1] ^ x[2] ^ x[3] ^ x[5];
  assign z[4] = x[0] ^ x[1];
  assign z[5] = x[1] ^ x[2] ^ x[4] ^ x[5];

  gf64_power26 u_power (
    .a (z),
    .b (w)
  );

  // inverse basis change
  assign p[0] = w[0] ^ w[1] ^ w[4] ^ w[5];
  assign p[1] = w[2] ^ w[4];
  assign p[2] = w[0] ^ w[1] ^ w[3] ^ w[4];
  assign p[3] = w[1] ^ w[2] ^ w[4];
  assign p[4] = w[0];
  assign p[5] = w[3] ^ w[4];

  // input parity flips the whole word, keeps it a bijection
  assign mask = x[2] ^ x[4];
  assign y = p ^ {sbox_pkg::LANE_W{mask}};

endmodule

//--- verilog/sbox_layer.sv
`timescale 1ns/1ps

module sbox_layer #(
  parameter int NUM_LANES = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req,
  input  sbox_pkg::sbox_block_t block_in,
  output logic                  ack,
  output sbox_pkg::sbox_block_t block_out
);

  localparam int CNT_W = $clog2(sbox_pkg::MAX_LANES);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_RUN  = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

  logic [1:0] state;
  logic [CNT_W-1:0] lane_cnt;
  logic last_lane;
  logic start;

  sbox_pkg::sbox_block_t src_q; // captured request block
  sbox_pkg::sbox_block_t res_q; // substituted lanes
  sbox_pkg::gf64_t lane_in;
  sbox_pkg::gf64_t lane_out;

  assign start = (state == ST_IDLE) && req;
  assign last_lane = (lane_cnt == CNT_W'(NUM_LANES - 1));

  // single shared S-box, one lane per cycle
  assign lane_in = src_q.lane[lane_cnt];

  sbox6 u_sbox (
    .x (lane_in),
    .y (lane_out)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      lane_cnt <= '0;
      ack <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req) begin
            state <= ST_RUN;
            lane_cnt <= '0;
          end
        end
        ST_RUN: begin
          if (last_lane) begin
            state <= ST_DONE;
          end else begin
            lane_cnt <= lane_cnt + 1'b1;
          end
        end
        ST_DONE: begin
          if (!ack) begin
            ack <= 1'b1; // one cycle after the last lane write
          end else if (!req) begin
            ack <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      src_q <= block_in;
    end
  end

  // only written while running, so held stable during ack
  always_ff @(posedge clk) begin
    if (rst) begin
      res_q <= '0;
    end else if (state == ST_RUN) begin
      res_q.lane[lane_cnt] <= lane_out;
    end
  end

  assign block_out = res_q;

endmodule

//--- verilog/sbox_unit_top.sv
`timescale 1ns/1ps

module sbox_unit_top #(
  parameter int NUM_LANES = 8 // lanes used per block, up to MAX_LANES
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req,
  input  sbox_pkg::sbox_block_t block_in,
  output logic                  ack,
  output sbox_pkg::sbox_block_t block_out
);

  // host four-phase handshake goes straight to the lane sequencer
  sbox_layer #(
    .NUM_LANES (NUM_LANES)
  ) u_layer (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .block_in  (block_in),
    .ack       (ack),
    .block_out (block_out)
  );

endmodule

//--- tests/sbox_model.svh
`ifndef SBOX_MODEL_SVH
`define SBOX_MODEL_SVH

// basis matrices over GF(2), row i in bits 6*i+5:6*i, bit j of a row selects input bit j
localparam logic [35:0] TO_COMPOSITE_ROWS = {
  6'b110110, 6'b000011, 6'b101110, 6'b001001, 6'b010000, 6'b110001
};
localparam logic [35:0] TO_STANDARD_ROWS = {
  6'b011000, 6'b000001, 6'b010110, 6'b011011, 6'b010100, 6'b110011
};

function automatic sbox_pkg::gf64_t apply_gf2_matrix(input logic [35:0] rows,
                                                     input sbox_pkg::gf64_t v);
  sbox_pkg::gf64_t r;
  int i;
  for (i = 0; i < 6; i++) begin
    r[i] = ^(rows[6*i +: 6] & v); // dot product over GF(2)
  end
  return r;
endfunction

// z^26 written per output digit, from the composite-field coordinate formulas
function automatic sbox_pkg::gf64_t power26_digits(input sbox_pkg::gf64_t z);
  sbox_pkg::gf4_t y0;
  sbox_pkg::gf4_t y1;
  sbox_pkg::gf4_t y2;
  sbox_pkg::gf4_t s0;
  sbox_pkg::gf4_t s1;
  sbox_pkg::gf4_t s2;
  sbox_pkg::gf4_t c01;
  sbox_pkg::gf4_t c02;
  sbox_pkg::gf4_t c12;
  sbox_pkg::gf4_t t0;
  sbox_pkg::gf4_t t1;
  sbox_pkg::gf4_t t2;
  sbox_pkg::gf4_t d0;
  sbox_pkg::gf4_t d1;
  sbox_pkg::gf4_t d2;
  y0 = z[1:0];
  y1 = z[3:2];
  y2 = z[5:4];
  s0 = sbox_pkg::gf4_sq(y0);
  s1 = sbox_pkg::gf4_sq(y1);
  s2 = sbox_pkg::gf4_sq(y2);
  c01 = sbox_pkg::gf4_mul(y0, y1);
  c02 = sbox_pkg::gf4_mul(y0, y2);
  c12 = sbox_pkg::gf4_mul(y1, y2);
  t0 = sbox_pkg::gf4_mul(y0, sbox_pkg::gf4_mul(s1, s2)); // y0 * y1^2 * y2^2
  t1 = sbox_pkg::gf4_mul(y1, sbox_pkg::gf4_mul(s0, s2));
  t2 = sbox_pkg::gf4_mul(y2, sbox_pkg::gf4_mul(s0, s1));
  d0 = sbox_pkg::gf4_add(s1, s2) ^ sbox_pkg::gf4_qube_scale(y2, s0)
     ^ sbox_pkg::gf4_qube_scale(y0, s1) ^ sbox_pkg::gf4_qube_scale(y2, s1)
     ^ c01 ^ c12 ^ t0 ^ t1;
  d1 = sbox_pkg::gf4_add(s0, s2) ^ sbox_pkg::gf4_qube_scale(y0, s1)
     ^ sbox_pkg::gf4_qube_scale(y0, s2) ^ sbox_pkg::gf4_qube_scale(y1, s2)
     ^ c02 ^ c12 ^ t1 ^ t2;
  d2 = sbox_pkg::gf4_add(s0, s1) ^ sbox_pkg::gf4_qube_scale(y1, s0)
     ^ sbox_pkg::gf4_qube_scale(y2, s0) ^ sbox_pkg::gf4_qube_scale(y1, s2)
     ^ c01 ^ c02 ^ t0 ^ t2;
  return {d2, d1, d0};
endfunction

function automatic sbox_pkg::gf64_t expected_sbox(input sbox_pkg::gf64_t x);
  sbox_pkg::gf64_t z;
  sbox_pkg::gf64_t w;
  sbox_pkg::gf64_t p;
  logic mask;
  z = apply_gf2_matrix(TO_COMPOSITE_ROWS, x);
  w = power26_digits(z);
  p = apply_gf2_matrix(TO_STANDARD_ROWS, w);
  mask = x[2] ^ x[4]; // parity of input bits 2 and 4
  return p ^ {6{mask}};
endfunction

`endif

//--- tests/tb_sbox_unit.sv
`timescale 1ns/1ps

module tb_sbox_unit;

  localparam int NUM_LANES = 8;
  localparam int NUM_BLOCKS_ALL = 64 / NUM_LANES; // blocks that cover every input value
  localparam int NUM_RANDOM = 20;
  localparam int HOLD_CYCLES = 6;
  localparam int NUM_REQS = NUM_BLOCKS_ALL + NUM_RANDOM + 2;
  localparam int TIMEOUT_CYCLES = NUM_REQS * (NUM_LANES + 4) + HOLD_CYCLES + 40;

  logic clk;
  logic rst;
  logic req;
  sbox_pkg::sbox_block_t block_in;
  logic ack;
  sbox_pkg::sbox_block_t block_out;

  int seed;
  int cycle_cnt = 0;
  sbox_pkg::gf64_t sbox_outs [64]; // collected during the exhaustive pass

  `include "sbox_model.svh"

  sbox_unit_top #(
    .NUM_LANES (NUM_LANES)
  ) DUT (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .block_in  (block_in),
    .ack       (ack),
    .block_out (block_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: a handshake did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $fatal(1, "run stopped on timeout");
    end
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Testbench failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic fill_random_block(output sbox_pkg::sbox_block_t blk);
    int l;
    for (l = 0; l < sbox_pkg::MAX_LANES; l++) begin
      blk.lane[l] = sbox_pkg::gf64_t'($random(seed)); // unused lanes get noise too
    end
  endtask

  // entered and left on a falling edge
  task automatic run_transfer(input sbox_pkg::sbox_block_t blk, input int hold,
                              output sbox_pkg::sbox_block_t res, output int lat);
    sbox_pkg::sbox_block_t held;
    int n;
    block_in = blk;
    req = 1'b1;
    n = 0;
    @(negedge clk); // capture edge has passed
    while (!ack) begin
      @(negedge clk);
      n++;
    end
    lat = n;
    held = block_out;
    repeat (hold) begin
      @(negedge clk);
      check_value("ack", ack, 1'b1);
      check_value("block_out", block_out, held);
    end
    req = 1'b0;
    @(negedge clk);
    check_value("ack", ack, 1'b0); // released on the first edge with req low
    res = held;
  endtask

  task automatic compare_lanes(input sbox_pkg::sbox_block_t sent,
                               input sbox_pkg::sbox_block_t res);
    int l;
    for (l = 0; l < NUM_LANES; l++) begin
      check_value($sformatf("block_out.lane[%0d]", l), res.lane[l],
                  expected_sbox(sent.lane[l]));
    end
  endtask

  task automatic check_reset_state();
    check_value("ack", ack, 1'b0);
    check_value("block_out", block_out, '0);
  endtask

  task automatic check_all_inputs();
    sbox_pkg::sbox_block_t blk;
    sbox_pkg::sbox_block_t res;
    int lat;
    int b;
    int l;
    for (b = 0; b < NUM_BLOCKS_ALL; b++) begin
      blk = '0;
      for (l = 0; l < NUM_LANES; l++) begin
        blk.lane[l] = sbox_pkg::gf64_t'(b * NUM_LANES + l);
      end
      run_transfer(blk, 0, res, lat);
      compare_lanes(blk, res);
      for (l = 0; l < NUM_LANES; l++) begin
        sbox_outs[b * NUM_LANES + l] = res.lane[l];
      end
    end
  endtask

  task automatic check_permutation();
    logic [63:0] seen;
    int distinct;
    int i;
    seen = '0;
    distinct = 0;
    for (i = 0; i < 64; i++) begin
      if (!seen[sbox_outs[i]]) begin
        seen[sbox_outs[i]] = 1'b1;
        distinct++;
      end
    end
    check_value("distinct_sbox_outputs", distinct, 64);
  endtask

  task automatic check_latency();
    sbox_pkg::sbox_block_t blk;
    sbox_pkg::sbox_block_t res;
    int lat;
    fill_random_block(blk);
    run_transfer(blk, 0, res, lat);
    check_value("ack_latency", lat, NUM_LANES + 1); // capture plus one cycle per lane
    compare_lanes(blk, res);
  endtask

  task automatic check_held_request();
    sbox_pkg::sbox_block_t blk;
    sbox_pkg::sbox_block_t res;
    int lat;
    fill_random_block(blk);
    run_transfer(blk, HOLD_CYCLES, res, lat);
    compare_lanes(blk, res);
  endtask

  task automatic check_random_blocks();
    sbox_pkg::sbox_block_t blk;
    sbox_pkg::sbox_block_t res;
    int lat;
    repeat (NUM_RANDOM) begin
      fill_random_block(blk);
      run_transfer(blk, 0, res, lat);
      compare_lanes(blk, res);
    end
  endtask

  initial begin
    seed = 32'h22a0;
    rst = 1'b1;
    req = 1'b0;
    block_in = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    check_reset_state();
    check_all_inputs();
    check_permutation();
    check_latency();
    check_held_request();
    check_random_blocks();
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- project.f
+incdir+tests
verilog/sbox_pkg.sv
verilog/gf64_power26.sv
verilog/sbox6.sv
verilog/sbox_layer.sv
verilog/sbox_unit_top.sv
tests/tb_sbox_unit.sv

//--- Bender.yml
package:
  name: sbox_unit

sources:
  - files:
      - verilog/sbox_pkg.sv
      - verilog/gf64_power26.sv
      - verilog/sbox6.sv
      - verilog/sbox_layer.sv
      - verilog/sbox_unit_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_sbox_unit.sv
